//--- verilog/ms6205_macros.svh
`ifndef MS6205_MACROS_SVH
`define MS6205_MACROS_SVH

// Character panel geometry, fixed by the display hardware
`define MS_COLUMNS   16
`define MS_ROWS      10
`define MS_MAX_POS   (`MS_COLUMNS * `MS_ROWS)

// Bit positions inside the 40-bit panel key-state vector
`define KEY_PROGRAM  16  // Show instruction memory
`define KEY_DATA     17  // Show data view
`define KEY_CONSOLE  18  // Show console output
`define KEY_HARD_RST 39  // Restart the display

`endif

//--- verilog/ms6205Pkg.sv
package ms6205Pkg;

    // Display views, encoded as on the original panel
    typedef enum logic [2:0] {
        viewRestart = 3'b000,
        viewProgram = 3'b010,
        viewData    = 3'b011,
        viewConsole = 3'b101
    } viewMode;

    // Instruction codes shown in the program view
    typedef enum logic [3:0] {
        opNop      = 4'h0,
        opLoad     = 4'h1,
        opStore    = 4'h2,
        opAdd      = 4'h3,
        opSub      = 4'h4,
        opAnd      = 4'h5,
        opInc      = 4'h6,
        opDec      = 4'h7,
        opShift    = 4'h8,
        opJump     = 4'h9,
        opJumpZero = 4'hA,
        opCall     = 4'hB,
        opReturn   = 4'hC,
        opIn       = 4'hD,
        opOut      = 4'hE,
        opHalt     = 4'hF
    } opcode;

    // CPU control phases seen by the panel
    typedef enum logic [2:0] {
        phaseIdle    = 3'd0,
        phaseFetch   = 3'd1,
        phaseDecode  = 3'd2,  // Marker is lit in this phase
        phaseExecute = 3'd3,
        phaseWrite   = 3'd4
    } cpuPhase;

endpackage

//--- verilog/viewSelector.sv
`timescale 1ns/1ps
`include "ms6205_macros.svh"

module viewSelector (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                refreshTick,
    input  logic [39:0]         keys,
    input  logic                cioAcq,
    input  ms6205Pkg::cpuPhase  dpcState,
    output ms6205Pkg::viewMode  view,
    output logic                marker
);

    ms6205Pkg::viewMode nextView;

    logic programKey;
    logic dataKey;
    logic consoleKey;
    logic hardRstKey;

    assign programKey = keys[`KEY_PROGRAM];
    assign dataKey    = keys[`KEY_DATA];
    assign consoleKey = keys[`KEY_CONSOLE];
    assign hardRstKey = keys[`KEY_HARD_RST];

    // Priority order matches the panel key layout
    always_comb begin
        if (view == ms6205Pkg::viewRestart) begin
            nextView = ms6205Pkg::viewProgram;  // Restart always lands on program view
        end else if (programKey) begin
            nextView = ms6205Pkg::viewProgram;
        end else if (dataKey) begin
            nextView = ms6205Pkg::viewData;
        end else if (consoleKey || cioAcq) begin
            nextView = ms6205Pkg::viewConsole;  // Pending output pulls console up
        end else if (hardRstKey) begin
            nextView = ms6205Pkg::viewRestart;
        end else begin
            nextView = view;
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            view <= ms6205Pkg::viewRestart;
        end else if (refreshTick) begin
            view <= nextView;                   // Views only change on refresh
        end
    end

    // Lit while the program view tracks the decode step
    assign marker = (view == ms6205Pkg::viewProgram) &&
                    (dpcState == ms6205Pkg::phaseDecode);

endmodule

//--- verilog/consoleBuffer.sv
`timescale 1ns/1ps
`include "ms6205_macros.svh"

module consoleBuffer (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                cout,
    input  logic [7:0]          symbol,
    input  ms6205Pkg::viewMode  view,
    input  logic [7:0]          readAddr,
    output logic                cioAcq,
    output logic [7:0]          readData
);

    logic [7:0] consoleRam [0:`MS_MAX_POS-1];
    logic [7:0] writePtr;
    logic [7:0] writePtrNext;
    logic       takeChar;
    logic       releaseAcq;

    // A new character is accepted only while no acknowledge is pending
    assign takeChar = cout && !cioAcq;

    // Acknowledge drops once the CPU let go and the console is visible
    assign releaseAcq = !cout && cioAcq && (view == ms6205Pkg::viewConsole);

    assign writePtrNext = (writePtr == 8'(`MS_MAX_POS - 1)) ? 8'h00
                                                             : writePtr + 8'h01;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            cioAcq   <= 1'b0;
            writePtr <= 8'h00;
        end else begin
            if (takeChar) begin
                cioAcq   <= 1'b1;
                writePtr <= writePtrNext;       // Wraps at end of screen
            end else if (releaseAcq) begin
                cioAcq <= 1'b0;
            end
        end
    end

    // Character storage
    always_ff @(posedge Clk) begin
        if (takeChar) begin
            consoleRam[writePtr] <= symbol;
        end
    end

    // Scanner side read, combinational
    assign readData = consoleRam[readAddr];

endmodule

//--- verilog/programMirror.sv
`timescale 1ns/1ps
`include "ms6205_macros.svh"

module programMirror (
    input  logic              Clk,
    input  logic [7:0]        ip,
    input  ms6205Pkg::opcode  romData,
    input  logic [7:0]        readAddr,
    output logic [7:0]        glyph
);

    ms6205Pkg::opcode insnRam [0:`MS_MAX_POS-1];
    ms6205Pkg::opcode readOp;
    logic             ipOnScreen;

    // Only the first screen of program memory is mirrored
    assign ipOnScreen = (ip < 8'(`MS_MAX_POS));

    // Follow the fetch stream every cycle
    always_ff @(posedge Clk) begin
        if (ipOnScreen) begin
            insnRam[ip] <= romData;
        end
    end

    assign readOp = insnRam[readAddr];

    // Opcode glyphs live in the upper half of the character set
    assign glyph = 8'h80 | {4'h0, readOp};

endmodule

//--- verilog/displayScanner.sv
`timescale 1ns/1ps
`include "ms6205_macros.svh"

module displayScanner (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                refreshTick,
    input  ms6205Pkg::viewMode  view,
    input  logic [7:0]          glyph,
    input  logic [7:0]          consoleData,
    output logic [7:0]          address,
    output logic [7:0]          dataN
);

    logic [7:0] charLatch;
    logic [7:0] charSel;
    logic       lastPos;

    assign lastPos = (address == 8'(`MS_MAX_POS - 1));

    // Program view shows glyphs; data and console share the console bytes
    assign charSel = (view == ms6205Pkg::viewProgram) ? glyph : consoleData;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            address   <= 8'h00;
            charLatch <= 8'h00;
        end else if (refreshTick) begin
            charLatch <= charSel;               // Character for the old address
            if (lastPos) begin
                address <= 8'h00;
            end else begin
                address <= address + 8'h01;
            end
        end
    end

    // Panel data lines are active low
    assign dataN = ~charLatch;

endmodule

//--- verilog/ms6205Display.sv
`timescale 1ns/1ps

module ms6205Display (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                refreshTick,
    input  logic                cout,
    input  logic [7:0]          symbol,
    input  logic [39:0]         keys,
    input  logic [7:0]          ip,
    input  ms6205Pkg::opcode    romData,
    input  ms6205Pkg::cpuPhase  dpcState,
    output logic                cioAcq,
    output logic [7:0]          address,
    output logic [7:0]          dataN,
    output logic                marker
);

    ms6205Pkg::viewMode view;
    logic [7:0]         glyph;
    logic [7:0]         consoleData;

    viewSelector uViewSelector (
        .Clk         (Clk),
        .arstN       (arstN),
        .refreshTick (refreshTick),
        .keys        (keys),
        .cioAcq      (cioAcq),
        .dpcState    (dpcState),
        .view        (view),
        .marker      (marker)
    );

    consoleBuffer uConsoleBuffer (
        .Clk      (Clk),
        .arstN    (arstN),
        .cout     (cout),
        .symbol   (symbol),
        .view     (view),
        .readAddr (address),    // Scan address drives both memories
        .cioAcq   (cioAcq),
        .readData (consoleData)
    );

    programMirror uProgramMirror (
        .Clk      (Clk),
        .ip       (ip),
        .romData  (romData),
        .readAddr (address),
        .glyph    (glyph)
    );

    displayScanner uDisplayScanner (
        .Clk         (Clk),
        .arstN       (arstN),
        .refreshTick (refreshTick),
        .view        (view),
        .glyph       (glyph),
        .consoleData (consoleData),
        .address     (address),
        .dataN       (dataN)
    );

endmodule

//--- verification/ms6205Tb.sv
`timescale 1ns/1ps
`include "ms6205_macros.svh"

module ms6205Tb;

    logic                Clk;
    logic                arstN;
    logic                refreshTick;
    logic                cout;
    logic [7:0]          symbol;
    logic [39:0]         keys;
    logic [7:0]          ip;
    ms6205Pkg::opcode    romData;
    ms6205Pkg::cpuPhase  dpcState;
    logic                cioAcq;
    logic [7:0]          address;
    logic [7:0]          dataN;
    logic                marker;

    logic [7:0]       expConsole [0:`MS_MAX_POS-1];  // Reference console memory
    ms6205Pkg::opcode expProgram [0:`MS_MAX_POS-1];  // Reference program memory
    int               expWrPtr;
    int               errorCount;
    int               timeoutCount;

    ms6205Display UUT (
        .Clk         (Clk),
        .arstN       (arstN),
        .refreshTick (refreshTick),
        .cout        (cout),
        .symbol      (symbol),
        .keys        (keys),
        .ip          (ip),
        .romData     (romData),
        .dpcState    (dpcState),
        .cioAcq      (cioAcq),
        .address     (address),
        .dataN       (dataN),
        .marker      (marker)
    );

    always #20 Clk = ~Clk;  // 40 ns period

    task automatic checkView(input string name, input ms6205Pkg::viewMode expected,
                             input ms6205Pkg::viewMode actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s expected %s (%b), got %s (%b)", $time, name,
                     expected.name(), expected, actual.name(), actual);
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle;
        @(posedge Clk);
        #2;
    endtask

    task automatic tick;
        nextCycle();
        refreshTick = 1'b1;
        nextCycle();
        refreshTick = 1'b0;
        #1;
    endtask

    task automatic pressKey(input logic [39:0] mask);
        nextCycle();
        keys        = mask;
        refreshTick = 1'b1;
        nextCycle();
        keys        = 40'd0;
        refreshTick = 1'b0;
        #1;
    endtask

    task automatic scanTo(input logic [7:0] target);
        int guard;
        guard = 0;
        while (address !== target && guard < 2 * `MS_MAX_POS) begin
            tick();
            guard++;
        end
        if (address !== target) begin
            timeoutCount++;
            $display("Timeout: scan address never reached %0d", target);
        end
    endtask

    task automatic loadProgram;
        for (int p = 0; p < `MS_MAX_POS; p++) begin
            nextCycle();
            ip            = 8'(p);
            romData       = ms6205Pkg::opcode'(4'($urandom()));
            expProgram[p] = romData;
        end
        nextCycle();
        ip = 8'hFF;  // Park the fetch pointer off screen
    endtask

    task automatic sendChar(input logic [7:0] ch);
        int guard;
        guard = 0;
        nextCycle();
        cout   = 1'b1;
        symbol = ch;
        nextCycle();
        while (cioAcq !== 1'b1 && guard < 20) begin
            nextCycle();
            guard++;
        end
        cout = 1'b0;
        if (cioAcq !== 1'b1) begin
            timeoutCount++;
            $display("Timeout: cioAcq never rose for character %h", ch);
        end else begin
            expConsole[expWrPtr] = ch;
            expWrPtr = (expWrPtr + 1) % `MS_MAX_POS;
        end
    endtask

    task automatic waitAckClear;
        int guard;
        guard = 0;
        while (cioAcq !== 1'b0 && guard < 20) begin
            tick();
            guard++;
        end
        if (cioAcq !== 1'b0) begin
            timeoutCount++;
            $display("Timeout: cioAcq never cleared");
        end
    endtask

    task automatic scanConsole(input int first, input int count);
        scanTo(8'(first));
        for (int i = 0; i < count; i++) begin
            tick();
            checkByte("dataN", ~expConsole[first + i], dataN);
        end
    endtask

    task automatic resetState;
        checkByte("address", 8'h00, address);
        checkByte("dataN", 8'hFF, dataN);
        checkBit("cioAcq", 1'b0, cioAcq);
        checkView("view", ms6205Pkg::viewRestart, UUT.view);
        nextCycle();
        dpcState = ms6205Pkg::phaseDecode;
        tick();
        checkView("view", ms6205Pkg::viewProgram, UUT.view);
        checkBit("marker", 1'b1, marker);
    endtask

    task automatic programFrame;
        logic [7:0] prev;
        loadProgram();
        scanTo(8'h00);
        for (int i = 0; i < `MS_MAX_POS; i++) begin
            prev = address;
            tick();
            checkByte("dataN", ~(8'h80 | 8'(expProgram[prev])), dataN);
            checkByte("address", 8'((int'(prev) + 1) % `MS_MAX_POS), address);
        end
    endtask

    task automatic consoleHandshake;
        sendChar(8'($urandom()));
        repeat (3) nextCycle();
        checkBit("cioAcq", 1'b1, cioAcq);  // Held while console is hidden
        checkView("view", ms6205Pkg::viewProgram, UUT.view);
        tick();
        checkView("view", ms6205Pkg::viewConsole, UUT.view);
        checkBit("marker", 1'b0, marker);
        nextCycle();
        #1;
        checkBit("cioAcq", 1'b0, cioAcq);
        scanConsole(0, 1);
    endtask

    task automatic backPressure;
        pressKey(40'd1 << `KEY_DATA);
        checkView("view", ms6205Pkg::viewData, UUT.view);
        sendChar(8'($urandom()));
        nextCycle();
        cout   = 1'b1;          // Should be ignored while acknowledged
        symbol = 8'($urandom());
        repeat (3) nextCycle();
        checkBit("cioAcq", 1'b1, cioAcq);
        cout = 1'b0;
        waitAckClear();
        repeat (3) begin
            sendChar(8'($urandom()));
            waitAckClear();
        end
        scanConsole(0, expWrPtr);
    endtask

    task automatic keyPriority;
        pressKey((40'd1 << `KEY_DATA) | (40'd1 << `KEY_CONSOLE));
        checkView("view", ms6205Pkg::viewData, UUT.view);
        checkBit("marker", 1'b0, marker);
        scanConsole(0, 1);     // Data view shows console bytes
        pressKey((40'd1 << `KEY_PROGRAM) | (40'd1 << `KEY_DATA) |
                 (40'd1 << `KEY_CONSOLE) | (40'd1 << `KEY_HARD_RST));
        checkView("view", ms6205Pkg::viewProgram, UUT.view);
        checkBit("marker", 1'b1, marker);
        pressKey((40'd1 << `KEY_CONSOLE) | (40'd1 << `KEY_HARD_RST));
        checkView("view", ms6205Pkg::viewConsole, UUT.view);
        checkBit("marker", 1'b0, marker);
        pressKey(40'd1 << `KEY_HARD_RST);
        checkView("view", ms6205Pkg::viewRestart, UUT.view);
        checkBit("marker", 1'b0, marker);
        tick();
        checkView("view", ms6205Pkg::viewProgram, UUT.view);
        checkBit("marker", 1'b1, marker);
        nextCycle();
        dpcState = ms6205Pkg::phaseExecute;  // Marker follows the decode phase only
        #1;
        checkBit("marker", 1'b0, marker);
    endtask

    initial begin
        void'($urandom(81010));
        Clk          = 1'b0;
        arstN        = 1'b0;
        refreshTick  = 1'b0;
        cout         = 1'b0;
        symbol       = 8'h00;
        keys         = 40'd0;
        ip           = 8'hFF;
        romData      = ms6205Pkg::opNop;
        dpcState     = ms6205Pkg::phaseIdle;
        expWrPtr     = 0;
        errorCount   = 0;
        timeoutCount = 0;
        repeat (10) @(posedge Clk);
        #2;
        arstN = 1'b1;
        #1;

        resetState();
        programFrame();
        consoleHandshake();
        backPressure();
        keyPriority();

        $display("Summary: %0d errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/ms6205Pkg.sv
verilog/viewSelector.sv
verilog/consoleBuffer.sv
verilog/programMirror.sv
verilog/displayScanner.sv
verilog/ms6205Display.sv
verification/ms6205Tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the display testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f --top-module ms6205Tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/Vms6205Tb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qF "** PASS **"; then
    exit 0
fi
exit 1
